// ==== hw/cdcMergePkg.sv ====
/* Sizes are fixed for two producer channels sharing one write clock
   The FIFO depth must stay a power of two of at least 4 entries */

package cdcMergePkg;

    // ======================================================================
    // FIFO geometry
    // ======================================================================

    // Address width of each channel FIFO
    // The depth is 2**ADDR_WID, so the value 2 gives 4 entries per channel
    // The pointers inside the FIFO carry one more bit than this to mark a wrap
    localparam int ADDR_WID = 2;

    // Width of one payload word, which is one byte from a producer
    localparam int DATA_WID = 8;

    // ======================================================================
    // Channel layout
    // ======================================================================

    // Number of producers merged onto the output bus
    // The arbiter is written for exactly two of them
    localparam int NUM_CHANNELS = 2;

    // Width of the channel tag that goes out next to each data byte
    localparam int CH_ID_WID = 1;

    // Identity of a producer channel
    // The arbiter uses it for its priority pointer and for the output tag,
    // and the same encoding is what a consumer sees on the tag wires
    typedef enum logic [CH_ID_WID-1:0] {
        CH_ZERO = 1'b0,
        CH_ONE  = 1'b1
    } chanIdE;

endpackage

// ==== hw/asyncFifo.sv ====
/* Dual-clock FIFO with Gray-coded pointers, depth 2**ADDR_WID with ADDR_WID >= 2
   Read data is registered, so a popped word shows up on the edge after the pop */

`timescale 1ns/1ps

module asyncFifo #(
    parameter int ADDR_WID = cdcMergePkg::ADDR_WID,
    parameter int DATA_WID = cdcMergePkg::DATA_WID
) (
    input  logic                w_clk_i,
    input  logic                r_clk_i,
    input  logic                rstN_i,

    // Write side, w_clk_i domain
    input  logic                wrValid_i,
    input  logic [DATA_WID-1:0] wrData_i,
    output logic                wrFull_o,

    // Read side, r_clk_i domain
    input  logic                rdPop_i,
    output logic                rdEmpty_o,
    output logic [DATA_WID-1:0] rdData_o
);

    // Storage shared by both domains
    // Written only in the write domain and read only in the read domain
    logic [DATA_WID-1:0] mem [2**ADDR_WID];

    // Both pointers have one extra wrap bit above the address bits
    // With it all entries are usable, and equal addresses with different
    // wrap bits mean full while fully equal pointers mean empty
    logic [ADDR_WID:0] wBin;
    logic [ADDR_WID:0] wBinNext;
    logic [ADDR_WID:0] wGray;
    logic [ADDR_WID:0] wGrayNext;
    logic [ADDR_WID:0] rBin;
    logic [ADDR_WID:0] rBinNext;
    logic [ADDR_WID:0] rGray;
    logic [ADDR_WID:0] rGrayNext;

    // Gray pointers after the two-flop synchronizers of the opposite domain
    // Only one bit of a Gray pointer moves per step, so the second flop
    // always holds either the old or the new pointer, never a mix
    logic [ADDR_WID:0] rGraySyncA;
    logic [ADDR_WID:0] rGraySyncB;
    logic [ADDR_WID:0] wGraySyncA;
    logic [ADDR_WID:0] wGraySyncB;

    logic wrHandshake;
    logic rdHandshake;

    // ======================================================================
    // Write clock domain
    // ======================================================================

    assign wrHandshake = wrValid_i && !wrFull_o;

    assign wBinNext  = wBin + {{ADDR_WID{1'b0}}, wrHandshake};
    // Binary to Gray is a shift and an XOR
    assign wGrayNext = wBinNext ^ (wBinNext >> 1);

    // The Gray copy is registered from the next value, so it always matches
    // wBin and leaves this domain straight from a flop without any glitch
    always_ff @(posedge w_clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            wBin  <= '0;
            wGray <= '0;
        end else begin
            wBin  <= wBinNext;
            wGray <= wGrayNext;
        end
    end

    // Read pointer brought over into the write domain
    always_ff @(posedge w_clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            rGraySyncA <= '0;
            rGraySyncB <= '0;
        end else begin
            rGraySyncA <= rGray;
            rGraySyncB <= rGraySyncA;
        end
    end

    // Full in Gray code
    // The binary rule (wrap bits differ, address bits equal) maps to the top
    // two Gray bits being inverted and all lower Gray bits being equal
    // A lagging read pointer can only make full stay high a little longer
    assign wrFull_o =
        (wGray[ADDR_WID:ADDR_WID-1] == ~rGraySyncB[ADDR_WID:ADDR_WID-1]) &&
        (wGray[ADDR_WID-2:0] == rGraySyncB[ADDR_WID-2:0]);

    always_ff @(posedge w_clk_i) begin
        if (wrHandshake) begin
            mem[wBin[ADDR_WID-1:0]] <= wrData_i;
        end
    end

    // ======================================================================
    // Read clock domain
    // ======================================================================

    assign rdHandshake = rdPop_i && !rdEmpty_o;

    assign rBinNext  = rBin + {{ADDR_WID{1'b0}}, rdHandshake};
    assign rGrayNext = rBinNext ^ (rBinNext >> 1);

    always_ff @(posedge r_clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            rBin  <= '0;
            rGray <= '0;
        end else begin
            rBin  <= rBinNext;
            rGray <= rGrayNext;
        end
    end

    // Write pointer brought over into the read domain
    // A new word becomes visible here two to three read edges after its write
    always_ff @(posedge r_clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            wGraySyncA <= '0;
            wGraySyncB <= '0;
        end else begin
            wGraySyncA <= wGray;
            wGraySyncB <= wGraySyncA;
        end
    end

    // Every Gray value is unique, so plain equality still means empty
    assign rdEmpty_o = (rGray == wGraySyncB);

    // Registered read of the entry the read pointer points at right now
    // On a pop edge this samples the word being popped, so the word is on
    // rdData_o for exactly the cycle that follows the pop
    // After that it is replaced by the next head entry
    always_ff @(posedge r_clk_i) begin
        rdData_o <= mem[rBin[ADDR_WID-1:0]];
    end

endmodule

// ==== hw/channelArbiter.sv ====
/* Round-robin drain of two FIFOs with one-cycle registered read data
   At most two words are in flight, one in capture and one on the output register */

`timescale 1ns/1ps

module channelArbiter (
    input  logic                                r_clk_i,
    input  logic                                rstN_i,

    // FIFO read ports
    input  logic [cdcMergePkg::NUM_CHANNELS-1:0] fifoEmpty_i,
    input  logic [cdcMergePkg::DATA_WID-1:0]     fifoData0_i,
    input  logic [cdcMergePkg::DATA_WID-1:0]     fifoData1_i,
    output logic [cdcMergePkg::NUM_CHANNELS-1:0] fifoPop_o,

    // Shared output bus with valid and ready
    input  logic                                outReady_i,
    output logic                                outValid_o,
    output logic [cdcMergePkg::DATA_WID-1:0]     outData_o,
    output cdcMergePkg::chanIdE                  outChan_o
);

    logic [cdcMergePkg::NUM_CHANNELS-1:0] nonEmpty;
    cdcMergePkg::chanIdE prioPtr;
    cdcMergePkg::chanIdE grantChan;
    logic grantValid;
    logic outFree;
    logic popAllowed;

    // Capture stage
    // capHeld low means the word is still on the FIFO data output this cycle,
    // capHeld high means it was parked in capData during a stall
    logic capValid;
    logic capHeld;
    cdcMergePkg::chanIdE capChan;
    logic [cdcMergePkg::DATA_WID-1:0] capData;
    logic [cdcMergePkg::DATA_WID-1:0] fifoWord;
    logic [cdcMergePkg::DATA_WID-1:0] capWord;

    assign nonEmpty = ~fifoEmpty_i;

    // The output register can take a new word when empty or being accepted
    assign outFree = !outValid_o || outReady_i;

    // A new pop needs the capture stage to be empty after this edge
    assign popAllowed = !capValid || outFree;

    // ======================================================================
    // Grant and pop
    // ======================================================================

    // The priority channel wins when it has data, else the other one
    // grantValid then also checks that the chosen FIFO really has data
    always_comb begin
        if (nonEmpty[prioPtr]) begin
            grantChan = prioPtr;
        end else begin
            grantChan = cdcMergePkg::chanIdE'(~prioPtr);
        end
        grantValid = popAllowed && nonEmpty[grantChan];
        fifoPop_o = '0;
        if (grantValid) begin
            fifoPop_o[grantChan] = 1'b1;
        end
    end

    // ======================================================================
    // Capture stage and output register
    // ======================================================================

    assign fifoWord = (capChan == cdcMergePkg::CH_ONE) ? fifoData1_i : fifoData0_i;
    assign capWord  = capHeld ? capData : fifoWord;

    always_ff @(posedge r_clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            prioPtr    <= cdcMergePkg::CH_ZERO;
            capValid   <= 1'b0;
            capHeld    <= 1'b0;
            capChan    <= cdcMergePkg::CH_ZERO;
            outValid_o <= 1'b0;
        end else begin
            // The loser of this grant goes first next time
            if (grantValid) begin
                prioPtr  <= cdcMergePkg::chanIdE'(~grantChan);
                capValid <= 1'b1;
                capHeld  <= 1'b0;
                capChan  <= grantChan;
            end else if (outFree) begin
                capValid <= 1'b0;
            end else if (capValid) begin
                // Output stalled, so the word moves into capData now
                capHeld <= 1'b1;
            end
            // Under back-pressure the output holds, else it takes the capture
            if (outFree) begin
                outValid_o <= capValid;
            end
        end
    end

    // Payload registers, qualified by the valid flags above
    always_ff @(posedge r_clk_i) begin
        if (capValid && !capHeld) begin
            capData <= fifoWord;
        end
        if (capValid && outFree) begin
            outData_o <= capWord;
            outChan_o <= capChan;
        end
    end

endmodule

// ==== hw/cdcMergeTop.sv ====
/* Two producers on w_clk_i merged onto one r_clk_i bus with a channel tag
   rstN_i is not synchronized and must be released while both clocks are quiet */

`timescale 1ns/1ps

module cdcMergeTop (
    input  logic                            w_clk_i,
    input  logic                            r_clk_i,
    input  logic                            rstN_i,

    // Producer of channel 0, w_clk_i domain
    input  logic                            ch0Valid_i,
    input  logic [cdcMergePkg::DATA_WID-1:0] ch0Data_i,
    output logic                            ch0Full_o,

    // Producer of channel 1, w_clk_i domain
    input  logic                            ch1Valid_i,
    input  logic [cdcMergePkg::DATA_WID-1:0] ch1Data_i,
    output logic                            ch1Full_o,

    // Merged output bus, r_clk_i domain
    input  logic                            outReady_i,
    output logic                            outValid_o,
    output logic [cdcMergePkg::DATA_WID-1:0] outData_o,
    output cdcMergePkg::chanIdE              outChan_o
);

    // Read-side wires between the FIFOs and the arbiter
    logic [cdcMergePkg::NUM_CHANNELS-1:0] fifoEmpty;
    logic [cdcMergePkg::NUM_CHANNELS-1:0] fifoPop;
    logic [cdcMergePkg::DATA_WID-1:0]     fifo0Data;
    logic [cdcMergePkg::DATA_WID-1:0]     fifo1Data;

    // One FIFO per producer, each crossing on its own Gray pointers
    asyncFifo fifoCh0 (
        .w_clk_i   (w_clk_i),
        .r_clk_i   (r_clk_i),
        .rstN_i    (rstN_i),
        .wrValid_i (ch0Valid_i),
        .wrData_i  (ch0Data_i),
        .wrFull_o  (ch0Full_o),
        .rdPop_i   (fifoPop[0]),
        .rdEmpty_o (fifoEmpty[0]),
        .rdData_o  (fifo0Data)
    );

    asyncFifo fifoCh1 (
        .w_clk_i   (w_clk_i),
        .r_clk_i   (r_clk_i),
        .rstN_i    (rstN_i),
        .wrValid_i (ch1Valid_i),
        .wrData_i  (ch1Data_i),
        .wrFull_o  (ch1Full_o),
        .rdPop_i   (fifoPop[1]),
        .rdEmpty_o (fifoEmpty[1]),
        .rdData_o  (fifo1Data)
    );

    // Round-robin drain onto the shared bus
    channelArbiter arbiter (
        .r_clk_i     (r_clk_i),
        .rstN_i      (rstN_i),
        .fifoEmpty_i (fifoEmpty),
        .fifoData0_i (fifo0Data),
        .fifoData1_i (fifo1Data),
        .fifoPop_o   (fifoPop),
        .outReady_i  (outReady_i),
        .outValid_o  (outValid_o),
        .outData_o   (outData_o),
        .outChan_o   (outChan_o)
    );

endmodule

// ==== dv/cdcMergeProps.sv ====
/* Protocol checks bound into asyncFifo and channelArbiter
   Unused ports of a binding are tied low, which leaves those properties vacuous */

`timescale 1ns/1ps

module cdcMergeProps #(
    parameter int POP_WID = 1
) (
    input logic                                 rClk_i,
    input logic                                 wClk_i,
    input logic                                 rstN_i,
    input logic [POP_WID-1:0]                   pop_i,
    input logic [POP_WID-1:0]                   empty_i,
    input logic [cdcMergePkg::ADDR_WID:0]       wrPtr_i,
    input logic                                 full_i,
    input logic                                 outValid_i,
    input logic                                 outReady_i,
    input logic [cdcMergePkg::DATA_WID-1:0]     outData_i,
    input logic [cdcMergePkg::CH_ID_WID-1:0]    outChan_i
);

    // A pop may only ever be raised on a FIFO that has data
    popNotEmpty: assert property (@(posedge rClk_i) disable iff (!rstN_i)
        !(|(pop_i & empty_i)))
        else $error("Pop raised on an empty FIFO");

    // A full FIFO keeps its write pointer, so no word is stored
    noWriteWhenFull: assert property (@(posedge wClk_i) disable iff (!rstN_i)
        full_i |=> $stable(wrPtr_i))
        else $error("Write pointer moved while the FIFO was full");

    // A stalled output word stays put until the consumer takes it
    holdWhenStalled: assert property (@(posedge rClk_i) disable iff (!rstN_i)
        (outValid_i && !outReady_i) |=>
            ($stable(outValid_i) && $stable(outData_i) && $stable(outChan_i)))
        else $error("Output bus changed while stalled");

endmodule

// ==== dv/cdcMergeTb.sv ====
/* Testbench for the two-channel merger with per-channel scoreboards
   Write clock runs at 14 ns and read clock at 10 ns, so the crossing is truly async */

`timescale 1ns/1ps

module cdcMergeTb;

    logic wClk;
    logic rClk;
    logic rstN;
    logic ch0Valid;
    logic ch1Valid;
    logic [7:0] ch0Data;
    logic [7:0] ch1Data;
    logic ch0Full;
    logic ch1Full;
    logic outReady;
    logic outValid;
    logic [7:0] outData;
    cdcMergePkg::chanIdE outChan;

    // Expected bytes per channel in write order
    logic [7:0] expQ0[$];
    logic [7:0] expQ1[$];
    int dataErrors;
    int timeoutErrors;
    // 0 holds ready low, 1 holds it high, 2 makes it random
    int readyMode;
    logic [31:0] rnd;
    bit fairMode;
    int fairCount;
    cdcMergePkg::chanIdE lastChan;

    // Stimulus table with channel, byte and idle gap in write cycles
    bit tblChan[24];
    logic [7:0] tblData[24];
    int tblGap[24];

    initial begin
        wClk = 1'b0;
        rClk = 1'b0;
    end

    always #5 rClk = ~rClk;
    always #7 wClk = ~wClk;

    cdcMergeTop UUT (
        .w_clk_i    (wClk),
        .r_clk_i    (rClk),
        .rstN_i     (rstN),
        .ch0Valid_i (ch0Valid),
        .ch0Data_i  (ch0Data),
        .ch0Full_o  (ch0Full),
        .ch1Valid_i (ch1Valid),
        .ch1Data_i  (ch1Data),
        .ch1Full_o  (ch1Full),
        .outReady_i (outReady),
        .outValid_o (outValid),
        .outData_o  (outData),
        .outChan_o  (outChan)
    );

    bind asyncFifo cdcMergeProps #(.POP_WID(1)) fifoProps (
        .rClk_i(r_clk_i), .wClk_i(w_clk_i), .rstN_i(rstN_i),
        .pop_i(rdPop_i), .empty_i(rdEmpty_o),
        .wrPtr_i(wBin), .full_i(wrFull_o),
        .outValid_i(1'b0), .outReady_i(1'b0), .outData_i(8'h00), .outChan_i(1'b0)
    );

    bind channelArbiter cdcMergeProps #(.POP_WID(2)) arbProps (
        .rClk_i(r_clk_i), .wClk_i(r_clk_i), .rstN_i(rstN_i),
        .pop_i(fifoPop_o), .empty_i(fifoEmpty_i),
        .wrPtr_i('0), .full_i(1'b0),
        .outValid_i(outValid_o), .outReady_i(outReady_i),
        .outData_i(outData_o), .outChan_i(outChan_o)
    );

    // Consumer ready changes just after each read edge
    always @(posedge rClk) begin
        #1;
        rnd = $urandom();
        if (readyMode == 2) begin
            outReady = rnd[0];
        end else begin
            outReady = (readyMode == 1);
        end
    end

    // ======================================================================
    // Read-side monitor
    // ======================================================================

    // Sampled mid-cycle, so these are the values the next edge transfers
    always @(negedge rClk) begin
        if (rstN && outValid && outReady) begin
            checkTransfer();
        end
    end

    task automatic checkTransfer();
        logic [7:0] expWord;
        bit haveExp;
        int otherSize;
        haveExp = 1'b0;
        if (outChan == cdcMergePkg::CH_ONE) begin
            otherSize = expQ0.size();
            if (expQ1.size() > 0) begin
                expWord = expQ1.pop_front();
                haveExp = 1'b1;
            end
        end else begin
            otherSize = expQ1.size();
            if (expQ0.size() > 0) begin
                expWord = expQ0.pop_front();
                haveExp = 1'b1;
            end
        end
        assert (haveExp) else begin
            dataErrors++;
            $display("Transfer on channel %0d with no byte outstanding", outChan);
        end
        if (haveExp) begin
            assert (outData == expWord) else begin
                dataErrors++;
                $display("ERROR outData_o got %h expected %h", outData, expWord);
            end
        end
        // The first two outputs were already in the pipeline before ready rose
        if (fairMode) begin
            if (fairCount >= 2 && otherSize > 0) begin
                assert (outChan != lastChan) else begin
                    dataErrors++;
                    $display("ERROR outChan_o repeated %h", outChan);
                end
            end
            lastChan = outChan;
            fairCount++;
        end
    endtask

    // ======================================================================
    // Write-side tasks are all entered 1 ns after a write edge
    // ======================================================================

    task automatic writeByte(input bit ch, input logic [7:0] d);
        int waitCount;
        bit full;
        waitCount = 0;
        if (ch) begin
            ch1Valid = 1'b1;
            ch1Data = d;
        end else begin
            ch0Valid = 1'b1;
            ch0Data = d;
        end
        // Full only moves on a write edge, so mid-cycle tells what the next edge does
        @(negedge wClk);
        full = ch ? ch1Full : ch0Full;
        while (full && waitCount < 100) begin
            @(negedge wClk);
            full = ch ? ch1Full : ch0Full;
            waitCount++;
        end
        if (full) begin
            timeoutErrors++;
            $display("Write on channel %0d timed out while the FIFO stayed full", ch);
        end else if (ch) begin
            expQ1.push_back(d);
        end else begin
            expQ0.push_back(d);
        end
        @(posedge wClk);
        #1;
        ch0Valid = 1'b0;
        ch1Valid = 1'b0;
    endtask

    // Writes until full has blocked 20 cycles in a row, with ready held low
    task automatic fillChannel(input bit ch, input int expCount, input logic [7:0] base);
        int accepted;
        int stuck;
        bit full;
        logic [7:0] d;
        accepted = 0;
        stuck = 0;
        while (stuck < 20 && accepted < 8) begin
            d = base + 8'(accepted);
            if (ch) begin
                ch1Valid = 1'b1;
                ch1Data = d;
            end else begin
                ch0Valid = 1'b1;
                ch0Data = d;
            end
            @(negedge wClk);
            full = ch ? ch1Full : ch0Full;
            if (full) begin
                stuck++;
            end else begin
                stuck = 0;
                accepted++;
                if (ch) begin
                    expQ1.push_back(d);
                end else begin
                    expQ0.push_back(d);
                end
            end
            @(posedge wClk);
            #1;
        end
        ch0Valid = 1'b0;
        ch1Valid = 1'b0;
        assert (accepted == expCount) else begin
            dataErrors++;
            $display("ERROR ch%0dFull_o accepted %h expected %h", ch, accepted, expCount);
        end
    endtask

    task automatic drainQueues();
        int waitCount;
        waitCount = 0;
        while ((expQ0.size() > 0 || expQ1.size() > 0) && waitCount < 2000) begin
            @(posedge rClk);
            waitCount++;
        end
        if (expQ0.size() > 0 || expQ1.size() > 0) begin
            timeoutErrors++;
            $display("Output drain timed out with bytes still outstanding");
        end
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial begin
        void'($urandom(12));
        rstN = 1'b0;
        ch0Valid = 1'b0;
        ch1Valid = 1'b0;
        ch0Data = 8'h00;
        ch1Data = 8'h00;
        outReady = 1'b0;
        readyMode = 0;
        dataErrors = 0;
        timeoutErrors = 0;
        fairMode = 1'b0;
        fairCount = 0;
        lastChan = cdcMergePkg::CH_ZERO;
        tblChan = '{0, 1, 1, 0, 0, 0, 1, 0, 1, 1, 1, 0,
                    0, 1, 0, 1, 0, 0, 0, 1, 1, 1, 0, 1};
        tblData = '{8'h11, 8'hA0, 8'hA1, 8'h12, 8'h13, 8'h14, 8'hA2, 8'h15,
                    8'hA3, 8'hA4, 8'hA5, 8'h16, 8'h17, 8'hA6, 8'h18, 8'hA7,
                    8'h19, 8'h1A, 8'h1B, 8'hA8, 8'hA9, 8'hAA, 8'h1C, 8'hAB};
        tblGap = '{0, 0, 3, 0, 0, 0, 1, 5, 0, 0, 0, 2,
                   0, 0, 0, 0, 4, 0, 0, 0, 0, 1, 0, 0};

        // Reset values are checked mid-cycle over the 4 reset cycles
        repeat (4) begin
            @(negedge rClk);
            assert (!outValid && !ch0Full && !ch1Full) else begin
                dataErrors++;
                $display("ERROR reset outValid_o %h ch0Full_o %h ch1Full_o %h",
                         outValid, ch0Full, ch1Full);
            end
        end
        @(posedge rClk);
        #1;
        rstN = 1'b1;
        @(negedge rClk);
        assert (!outValid && !ch0Full && !ch1Full) else begin
            dataErrors++;
            $display("ERROR after reset outValid_o %h ch0Full_o %h ch1Full_o %h",
                     outValid, ch0Full, ch1Full);
        end

        // Table writes under random back-pressure
        readyMode = 2;
        @(posedge wClk);
        #1;
        for (int i = 0; i < 24; i++) begin
            repeat (tblGap[i]) begin
                @(posedge wClk);
                #1;
            end
            writeByte(tblChan[i], tblData[i]);
        end
        drainQueues();

        // With ready low, channel 0 also fills the arbiter pipeline before it goes full
        readyMode = 0;
        repeat (3) @(posedge rClk);
        @(posedge wClk);
        #1;
        fillChannel(1'b0, 6, 8'h40);
        fillChannel(1'b1, 4, 8'hC0);

        // Both FIFOs full, then release ready and watch the grants alternate
        fairMode = 1'b1;
        readyMode = 1;
        drainQueues();
        fairMode = 1'b0;

        // Ready stays high a while longer so a repeated last word would show up
        repeat (10) @(posedge rClk);

        $display("Closing counts: data errors %0d, timeouts %0d", dataErrors, timeoutErrors);
        if (dataErrors == 0 && timeoutErrors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
hw/cdcMergePkg.sv
hw/asyncFifo.sv
hw/channelArbiter.sv
hw/cdcMergeTop.sv
dv/cdcMergeProps.sv
dv/cdcMergeTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it; fails unless the pass line is printed
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module cdcMergeTb \
    --Mdir obj_dir -o cdcMergeSim \
  && simOut=$(./obj_dir/cdcMergeSim) \
  && echo "$simOut" \
  && echo "$simOut" | grep -q "^Simulation completed successfully$" \
  && echo "Run passed" \
  || { echo "Run failed"; exit 1; }
